//--- src/router_settings.svh
// Router build settings
// Port count, lookup table depth, header size and register map offsets
`ifndef ROUTER_SETTINGS_SVH
`define ROUTER_SETTINGS_SVH

// Ingress and egress stream ports
`define ROUTER_NUM_PORTS 2

// Destination MAC lookup table
`define ROUTER_MAC_ENTRIES 4
`define ROUTER_MAC_BYTES 6

// AXI4-Lite register space
`define ROUTER_AXIL_ADDR_W 8
`define ROUTER_REG_DROP_CNT 'h40

`endif

//--- src/eth_pkg.sv
// Packet-side types
// Stream bytes, MAC addresses, table entries and the classifier FSM
`include "router_settings.svh"

package eth_pkg;

    typedef logic [7:0] byte_t;
    typedef logic [8*`ROUTER_MAC_BYTES-1:0] mac_addr_t;
    typedef logic [$clog2(`ROUTER_NUM_PORTS)-1:0] port_id_t;

    // One lookup entry, valid in the top bit
    typedef struct packed {
        logic      valid;
        port_id_t  port;
        mac_addr_t mac;
    } mac_entry_t;

    typedef enum logic [1:0] {
        CAPTURE,
        FORWARD,
        DRAIN,
        DISCARD
    } class_state_t;

endpackage

//--- src/ctrl_pkg.sv
// Control-side types for the AXI4-Lite register block
`include "router_settings.svh"

package ctrl_pkg;

    typedef logic [`ROUTER_AXIL_ADDR_W-1:0] axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [31:0] drop_cnt_t;

    typedef enum logic {
        WR_IDLE,
        WR_RESP
    } axil_wr_state_t;

    typedef enum logic {
        RD_IDLE,
        RD_DATA
    } axil_rd_state_t;

endpackage

//--- src/pkt_stream_if.sv
// Internal byte stream between classifiers and egress arbiters
// Carries the packet bytes and the egress port picked by the lookup
`timescale 1ns/1ps

interface pkt_stream_if;
    import eth_pkg::*;

    byte_t    data;
    logic     valid;
    logic     ready;
    logic     last;
    // Held for the whole packet
    port_id_t dest;

    modport src (
        output data,
        output valid,
        output last,
        output dest,
        input  ready
    );

    modport dst (
        input  data,
        input  valid,
        input  last,
        input  dest,
        output ready
    );

endinterface

//--- src/axil_regs.sv
// AXI4-Lite register block
// Holds the MAC lookup table and the saturating drop counter
`timescale 1ns/1ps
`include "router_settings.svh"

module axil_regs (
    input  logic                          core_clk_ifc,
    input  logic                          i_rst_n,
    input  ctrl_pkg::axil_addr_t          i_s_axil_awaddr,
    input  logic                          i_s_axil_awvalid,
    output logic                          o_s_axil_awready,
    input  ctrl_pkg::axil_data_t          i_s_axil_wdata,
    input  logic                          i_s_axil_wvalid,
    output logic                          o_s_axil_wready,
    output logic [1:0]                    o_s_axil_bresp,
    output logic                          o_s_axil_bvalid,
    input  logic                          i_s_axil_bready,
    input  ctrl_pkg::axil_addr_t          i_s_axil_araddr,
    input  logic                          i_s_axil_arvalid,
    output logic                          o_s_axil_arready,
    output ctrl_pkg::axil_data_t          o_s_axil_rdata,
    output logic [1:0]                    o_s_axil_rresp,
    output logic                          o_s_axil_rvalid,
    input  logic                          i_s_axil_rready,
    output eth_pkg::mac_entry_t           o_mac_table [`ROUTER_MAC_ENTRIES],
    input  logic [`ROUTER_NUM_PORTS-1:0]  i_drop_pulse
);
    import ctrl_pkg::*;

    localparam int ENTRIES = `ROUTER_MAC_ENTRIES;
    localparam int IDX_W = $clog2(ENTRIES);
    localparam int SUM_W = $bits(drop_cnt_t) + 1;

    axil_wr_state_t   wr_state;
    axil_rd_state_t   rd_state;
    logic             wr_fire;
    logic             rd_fire;
    logic             wr_map;
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;
    axil_data_t       rd_word;
    drop_cnt_t        drop_cnt;
    logic [SUM_W-1:0] drop_sum;

    //////////////////////////////////////////////////
    // Write channel

    // AW and W taken together
    assign wr_fire = (wr_state == WR_IDLE) && i_s_axil_awvalid && i_s_axil_wvalid;
    assign o_s_axil_awready = wr_fire;
    assign o_s_axil_wready = wr_fire;
    assign o_s_axil_bvalid = (wr_state == WR_RESP);
    assign o_s_axil_bresp = 2'b00;

    assign wr_map = i_s_axil_awaddr < axil_addr_t'(8 * ENTRIES);
    assign wr_idx = i_s_axil_awaddr[3 +: IDX_W];

    always_ff @(posedge core_clk_ifc) begin : wr_fsm
        if (!i_rst_n) begin
            wr_state <= WR_IDLE;
        end else if (wr_state == WR_IDLE) begin
            if (wr_fire) begin
                wr_state <= WR_RESP;
            end
        end else if (i_s_axil_bready) begin
            wr_state <= WR_IDLE;
        end
    end

    // Entry words: low holds MAC[31:0], high holds valid, port and MAC[47:32]
    always_ff @(posedge core_clk_ifc) begin : table_write
        if (!i_rst_n) begin
            for (int e = 0; e < ENTRIES; e++) begin
                o_mac_table[e].valid <= 1'b0;
            end
        end else if (wr_fire && wr_map) begin
            if (i_s_axil_awaddr[2]) begin
                o_mac_table[wr_idx].mac[47:32] <= i_s_axil_wdata[15:0];
                o_mac_table[wr_idx].port <= i_s_axil_wdata[16];
                o_mac_table[wr_idx].valid <= i_s_axil_wdata[31];
            end else begin
                o_mac_table[wr_idx].mac[31:0] <= i_s_axil_wdata;
            end
        end
    end

    //////////////////////////////////////////////////
    // Read channel

    // No new AR while a response waits
    assign o_s_axil_arready = (rd_state == RD_IDLE);
    assign rd_fire = o_s_axil_arready && i_s_axil_arvalid;
    assign o_s_axil_rvalid = (rd_state == RD_DATA);
    assign o_s_axil_rresp = 2'b00;
    assign rd_idx = i_s_axil_araddr[3 +: IDX_W];

    always_comb begin : rd_decode
        rd_word = '0;
        if (i_s_axil_araddr == axil_addr_t'(`ROUTER_REG_DROP_CNT)) begin
            rd_word = drop_cnt;
        end else if (i_s_axil_araddr < axil_addr_t'(8 * ENTRIES)) begin
            if (i_s_axil_araddr[2]) begin
                rd_word = {o_mac_table[rd_idx].valid, 14'd0, o_mac_table[rd_idx].port,
                           o_mac_table[rd_idx].mac[47:32]};
            end else begin
                rd_word = o_mac_table[rd_idx].mac[31:0];
            end
        end
    end

    always_ff @(posedge core_clk_ifc) begin : rd_fsm
        if (!i_rst_n) begin
            rd_state <= RD_IDLE;
        end else if (rd_state == RD_IDLE) begin
            if (rd_fire) begin
                rd_state <= RD_DATA;
            end
        end else if (i_s_axil_rready) begin
            rd_state <= RD_IDLE;
        end
    end

    always_ff @(posedge core_clk_ifc) begin : rd_data
        if (rd_fire) begin
            o_s_axil_rdata <= rd_word;
        end
    end

    //////////////////////////////////////////////////
    // Drop counter

    // Coincident pulses from both ports all count
    always_comb begin : drop_add
        drop_sum = {1'b0, drop_cnt};
        for (int p = 0; p < `ROUTER_NUM_PORTS; p++) begin
            drop_sum = drop_sum + SUM_W'(i_drop_pulse[p]);
        end
    end

    always_ff @(posedge core_clk_ifc) begin : drop_count
        if (!i_rst_n) begin
            drop_cnt <= '0;
        end else if (drop_sum[SUM_W-1]) begin
            drop_cnt <= '1;
        end else begin
            drop_cnt <= drop_sum[SUM_W-2:0];
        end
    end

    // Write response held until the master takes it
    a_bvalid_hold: assert property (@(posedge core_clk_ifc) disable iff (!i_rst_n)
        o_s_axil_bvalid && !i_s_axil_bready |=> o_s_axil_bvalid);

endmodule

//--- src/ingress_classifier.sv
// Ingress classifier
// Captures the destination MAC, looks it up and forwards or drops the packet
`timescale 1ns/1ps
`include "router_settings.svh"

module ingress_classifier (
    input  logic                core_clk_ifc,
    input  logic                i_rst_n,
    input  eth_pkg::byte_t      i_tdata,
    input  logic                i_tvalid,
    input  logic                i_tlast,
    output logic                o_tready,
    input  eth_pkg::mac_entry_t i_mac_table [`ROUTER_MAC_ENTRIES],
    output logic                o_drop,
    pkt_stream_if.src           o_pkt
);
    import eth_pkg::*;

    localparam int HDR = `ROUTER_MAC_BYTES;
    localparam int CNT_W = $clog2(HDR + 1);

    class_state_t     state;
    // Header bytes captured, then bytes left to drain
    logic [CNT_W-1:0] cnt;
    logic             in_done;
    logic             cap_en;
    byte_t            hdr_buf [HDR];
    mac_addr_t        cap_mac;
    port_id_t         dest_q;
    port_id_t         hit_port;
    logic             hit;
    logic             lookup;
    logic             in_acc;
    logic             out_tx;
    logic             shift_en;

    assign lookup = (state == CAPTURE) && (cnt == CNT_W'(HDR));

    always_comb begin : ready_mux
        case (state)
            CAPTURE: o_tready = cap_en && (cnt != CNT_W'(HDR));
            FORWARD: o_tready = o_pkt.ready;
            DISCARD: o_tready = 1'b1;
            default: o_tready = 1'b0;
        endcase
    end

    assign in_acc = i_tvalid && o_tready;

    // Output lags input by HDR bytes, oldest byte at the front
    assign o_pkt.valid = (state == FORWARD) ? i_tvalid : (state == DRAIN);
    assign o_pkt.data = hdr_buf[0];
    assign o_pkt.last = (state == DRAIN) && (cnt == CNT_W'(1));
    assign o_pkt.dest = dest_q;
    assign out_tx = o_pkt.valid && o_pkt.ready;
    assign shift_en = (in_acc && (state != DISCARD)) || ((state == DRAIN) && out_tx);

    // First wire byte is the MAC's most significant byte
    always_comb begin : mac_lookup
        for (int k = 0; k < HDR; k++) begin
            cap_mac[8*(HDR-1-k) +: 8] = hdr_buf[k];
        end
        hit = 1'b0;
        hit_port = '0;
        // Lowest matching index wins
        for (int e = `ROUTER_MAC_ENTRIES - 1; e >= 0; e--) begin
            if (i_mac_table[e].valid && (i_mac_table[e].mac == cap_mac)) begin
                hit = 1'b1;
                hit_port = i_mac_table[e].port;
            end
        end
    end

    always_ff @(posedge core_clk_ifc) begin : hdr_shift
        if (shift_en) begin
            for (int k = 0; k < HDR - 1; k++) begin
                hdr_buf[k] <= hdr_buf[k+1];
            end
            hdr_buf[HDR-1] <= i_tdata;
        end
        if (lookup && hit) begin
            dest_q <= hit_port;
        end
    end

    //////////////////////////////////////////////////
    // Classifier FSM

    always_ff @(posedge core_clk_ifc) begin : fsm
        if (!i_rst_n) begin
            state <= CAPTURE;
            cnt <= '0;
            in_done <= 1'b0;
            cap_en <= 1'b0;
            o_drop <= 1'b0;
        end else begin
            cap_en <= 1'b1;
            o_drop <= 1'b0;
            case (state)
                CAPTURE: begin
                    if (lookup) begin
                        in_done <= 1'b0;
                        if (hit) begin
                            state <= in_done ? DRAIN : FORWARD;
                        end else begin
                            o_drop <= 1'b1;
                            cnt <= '0;
                            state <= in_done ? CAPTURE : DISCARD;
                        end
                    end else if (in_acc) begin
                        if (i_tlast && (cnt != CNT_W'(HDR - 1))) begin
                            // Runt, ends inside the MAC field
                            o_drop <= 1'b1;
                            cnt <= '0;
                        end else begin
                            cnt <= cnt + 1'b1;
                            in_done <= i_tlast;
                        end
                    end
                end
                FORWARD: begin
                    if (in_acc && i_tlast) begin
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    if (out_tx) begin
                        cnt <= cnt - 1'b1;
                        if (o_pkt.last) begin
                            state <= CAPTURE;
                        end
                    end
                end
                default: begin
                    if (in_acc && i_tlast) begin
                        state <= CAPTURE;
                    end
                end
            endcase
        end
    end

    // Stalled output holds its byte while the egress side waits
    a_stall_stable: assert property (@(posedge core_clk_ifc) disable iff (!i_rst_n)
        o_pkt.valid && !o_pkt.ready |=> $stable({o_pkt.data, o_pkt.last, o_pkt.dest}));

endmodule

//--- src/egress_arbiter.sv
// Egress arbiter
// Packet-atomic round-robin over the ingress streams aimed at this port
`timescale 1ns/1ps
`include "router_settings.svh"

module egress_arbiter #(
    parameter eth_pkg::port_id_t PORT_IDX = '0
) (
    input  logic                         core_clk_ifc,
    input  logic                         i_rst_n,
    pkt_stream_if.dst                    i_pkt [`ROUTER_NUM_PORTS],
    output eth_pkg::byte_t               o_tdata,
    output logic                         o_tvalid,
    output logic                         o_tlast,
    input  logic                         i_tready,
    output logic [`ROUTER_NUM_PORTS-1:0] o_grant
);
    import eth_pkg::*;

    localparam int N = `ROUTER_NUM_PORTS;

    logic [N-1:0] req;
    logic [N-1:0] last_arr;
    byte_t        data_arr [N];
    logic         locked;
    logic         any_req;
    logic         tx;
    // Last winner, also the owner while locked
    port_id_t     last_win;
    port_id_t     pick;
    port_id_t     cur;

    for (genvar g = 0; g < N; g++) begin : g_req
        assign req[g] = i_pkt[g].valid && (i_pkt[g].dest == PORT_IDX);
        assign data_arr[g] = i_pkt[g].data;
        assign last_arr[g] = i_pkt[g].last;
    end

    // Nearest requester after the last winner
    always_comb begin : rr_pick
        pick = last_win;
        for (int k = N; k >= 1; k--) begin
            if (req[(int'(last_win) + k) % N]) begin
                pick = port_id_t'((int'(last_win) + k) % N);
            end
        end
    end

    assign any_req = |req;
    assign cur = locked ? last_win : pick;
    assign o_tvalid = req[cur];
    assign o_tdata = data_arr[cur];
    assign o_tlast = last_arr[cur];
    assign tx = o_tvalid && i_tready;

    // Grant only to a valid stream for this port, so no byte goes astray
    always_comb begin : grant_vec
        o_grant = '0;
        o_grant[cur] = tx;
    end

    // Lock once a packet is offered so the choice cannot move under a stall
    always_ff @(posedge core_clk_ifc) begin : lock_ctrl
        if (!i_rst_n) begin
            locked <= 1'b0;
            last_win <= '0;
        end else if (!locked) begin
            if (any_req) begin
                last_win <= pick;
                locked <= !(tx && o_tlast);
            end
        end else if (tx && o_tlast) begin
            locked <= 1'b0;
        end
    end

    a_grant_onehot: assert property (@(posedge core_clk_ifc) disable iff (!i_rst_n)
        $onehot0(o_grant));

endmodule

//--- src/router_top.sv
// Packet router top level
// Ingress classifiers, egress arbiters and the AXI4-Lite table registers
`timescale 1ns/1ps
`include "router_settings.svh"

module router_top (
    input  logic                         core_clk_ifc,
    input  logic                         i_rst_n,
    input  eth_pkg::byte_t               i_ing_tdata [`ROUTER_NUM_PORTS],
    input  logic [`ROUTER_NUM_PORTS-1:0] i_ing_tvalid,
    input  logic [`ROUTER_NUM_PORTS-1:0] i_ing_tlast,
    output logic [`ROUTER_NUM_PORTS-1:0] o_ing_tready,
    output eth_pkg::byte_t               o_egr_tdata [`ROUTER_NUM_PORTS],
    output logic [`ROUTER_NUM_PORTS-1:0] o_egr_tvalid,
    output logic [`ROUTER_NUM_PORTS-1:0] o_egr_tlast,
    input  logic [`ROUTER_NUM_PORTS-1:0] i_egr_tready,
    input  ctrl_pkg::axil_addr_t         i_s_axil_awaddr,
    input  logic                         i_s_axil_awvalid,
    output logic                         o_s_axil_awready,
    input  ctrl_pkg::axil_data_t         i_s_axil_wdata,
    input  logic                         i_s_axil_wvalid,
    output logic                         o_s_axil_wready,
    output logic [1:0]                   o_s_axil_bresp,
    output logic                         o_s_axil_bvalid,
    input  logic                         i_s_axil_bready,
    input  ctrl_pkg::axil_addr_t         i_s_axil_araddr,
    input  logic                         i_s_axil_arvalid,
    output logic                         o_s_axil_arready,
    output ctrl_pkg::axil_data_t         o_s_axil_rdata,
    output logic [1:0]                   o_s_axil_rresp,
    output logic                         o_s_axil_rvalid,
    input  logic                         i_s_axil_rready
);
    import eth_pkg::*;

    localparam int N = `ROUTER_NUM_PORTS;

    mac_entry_t   mac_table [`ROUTER_MAC_ENTRIES];
    logic [N-1:0] drop_pulse;
    // Per egress port, one grant bit per ingress stream
    logic [N-1:0] egr_grant [N];
    logic [N-1:0] ing_ready;

    pkt_stream_if pkt [N] ();

    axil_regs u_regs (
        .core_clk_ifc     (core_clk_ifc),
        .i_rst_n          (i_rst_n),
        .i_s_axil_awaddr  (i_s_axil_awaddr),
        .i_s_axil_awvalid (i_s_axil_awvalid),
        .o_s_axil_awready (o_s_axil_awready),
        .i_s_axil_wdata   (i_s_axil_wdata),
        .i_s_axil_wvalid  (i_s_axil_wvalid),
        .o_s_axil_wready  (o_s_axil_wready),
        .o_s_axil_bresp   (o_s_axil_bresp),
        .o_s_axil_bvalid  (o_s_axil_bvalid),
        .i_s_axil_bready  (i_s_axil_bready),
        .i_s_axil_araddr  (i_s_axil_araddr),
        .i_s_axil_arvalid (i_s_axil_arvalid),
        .o_s_axil_arready (o_s_axil_arready),
        .o_s_axil_rdata   (o_s_axil_rdata),
        .o_s_axil_rresp   (o_s_axil_rresp),
        .o_s_axil_rvalid  (o_s_axil_rvalid),
        .i_s_axil_rready  (i_s_axil_rready),
        .o_mac_table      (mac_table),
        .i_drop_pulse     (drop_pulse)
    );

    // A stream is ready when the arbiter it targets grants it
    always_comb begin : ready_or
        ing_ready = '0;
        for (int e = 0; e < N; e++) begin
            ing_ready = ing_ready | egr_grant[e];
        end
    end

    for (genvar g = 0; g < N; g++) begin : g_port
        ingress_classifier u_ing (
            .core_clk_ifc (core_clk_ifc),
            .i_rst_n      (i_rst_n),
            .i_tdata      (i_ing_tdata[g]),
            .i_tvalid     (i_ing_tvalid[g]),
            .i_tlast      (i_ing_tlast[g]),
            .o_tready     (o_ing_tready[g]),
            .i_mac_table  (mac_table),
            .o_drop       (drop_pulse[g]),
            .o_pkt        (pkt[g])
        );

        assign pkt[g].ready = ing_ready[g];

        egress_arbiter #(
            .PORT_IDX (port_id_t'(g))
        ) u_egr (
            .core_clk_ifc (core_clk_ifc),
            .i_rst_n      (i_rst_n),
            .i_pkt        (pkt),
            .o_tdata      (o_egr_tdata[g]),
            .o_tvalid     (o_egr_tvalid[g]),
            .o_tlast      (o_egr_tlast[g]),
            .i_tready     (i_egr_tready[g]),
            .o_grant      (egr_grant[g])
        );
    end

endmodule

//--- tb/router_tb.sv
// Router testbench
// AXI4-Lite table setup and packet traffic, checked against per-port scoreboards
`timescale 1ns/1ps
`include "router_settings.svh"

module router_tb;
    import eth_pkg::*;
    import ctrl_pkg::*;

    localparam int N = `ROUTER_NUM_PORTS;
    localparam int HDR = `ROUTER_MAC_BYTES;
    localparam int TOTAL_PKTS = 40;
    localparam int MAX_LEN = 60;
    // Every byte of every packet, stretched by random back-pressure
    localparam int TIMEOUT_CYCLES = TOTAL_PKTS * MAX_LEN * 5 / 3;
    localparam mac_addr_t UNKNOWN_MAC = 48'h02_00_00_00_ee_05;
    // Even entries route to egress 0, odd entries to egress 1
    localparam mac_addr_t MACS [`ROUTER_MAC_ENTRIES] = '{
        48'h02_00_00_00_0a_01, 48'h02_00_00_00_0b_02,
        48'h02_00_00_00_0c_03, 48'h02_00_00_00_0d_04
    };

    logic         core_clk_ifc;
    logic         i_rst_n;
    byte_t        i_ing_tdata [N];
    logic [N-1:0] i_ing_tvalid;
    logic [N-1:0] i_ing_tlast;
    logic [N-1:0] o_ing_tready;
    byte_t        o_egr_tdata [N];
    logic [N-1:0] o_egr_tvalid;
    logic [N-1:0] o_egr_tlast;
    logic [N-1:0] i_egr_tready = '1;
    axil_addr_t   i_s_axil_awaddr;
    logic         i_s_axil_awvalid;
    logic         o_s_axil_awready;
    axil_data_t   i_s_axil_wdata;
    logic         i_s_axil_wvalid;
    logic         o_s_axil_wready;
    logic [1:0]   o_s_axil_bresp;
    logic         o_s_axil_bvalid;
    logic         i_s_axil_bready;
    axil_addr_t   i_s_axil_araddr;
    logic         i_s_axil_arvalid;
    logic         o_s_axil_arready;
    axil_data_t   o_s_axil_rdata;
    logic [1:0]   o_s_axil_rresp;
    logic         o_s_axil_rvalid;
    logic         i_s_axil_rready;

    integer       seed = 71077;
    bit           bp_en = 1'b0;
    int           cycles = 0;
    int           sent_pkts = 0;
    int           got_pkts = 0;
    // Expected {last, data} per egress and ingress pair, index egress * N + ingress
    logic [8:0]   exp_q [N*N][$];
    logic [8:0]   got_buf [N][$];

    router_top i_dut (.*);

    initial begin : clock_gen
        core_clk_ifc = 1'b0;
        forever #5 core_clk_ifc = ~core_clk_ifc;
    end

    always @(posedge core_clk_ifc) begin : timeout
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with traffic still pending", cycles);
            stop_on_failure();
        end
    end

    task automatic stop_on_failure();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERR %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    function automatic int random_len();
        return 8 + (($random(seed) & 32'h7fff_ffff) % (MAX_LEN - 7));
    endfunction

    function automatic int pending_bytes();
        int sum;
        sum = 0;
        for (int k = 0; k < N * N; k++) begin
            sum += exp_q[k].size();
        end
        for (int e = 0; e < N; e++) begin
            sum += got_buf[e].size();
        end
        return sum;
    endfunction

    //////////////////////////////////////////////////
    // AXI4-Lite master

    task automatic axil_write(input axil_addr_t addr, input axil_data_t data);
        @(posedge core_clk_ifc);
        #1;
        i_s_axil_awaddr = addr;
        i_s_axil_wdata = data;
        i_s_axil_awvalid = 1'b1;
        i_s_axil_wvalid = 1'b1;
        do @(negedge core_clk_ifc); while (!o_s_axil_awready);
        @(posedge core_clk_ifc);
        #1;
        i_s_axil_awvalid = 1'b0;
        i_s_axil_wvalid = 1'b0;
        while (!o_s_axil_bvalid) @(negedge core_clk_ifc);
        check_value("o_s_axil_bresp", 32'(o_s_axil_bresp), 32'd0);
        @(posedge core_clk_ifc);
        #1;
    endtask

    task automatic read_expect(input axil_addr_t addr, input axil_data_t exp);
        @(posedge core_clk_ifc);
        #1;
        i_s_axil_araddr = addr;
        i_s_axil_arvalid = 1'b1;
        do @(negedge core_clk_ifc); while (!o_s_axil_arready);
        @(posedge core_clk_ifc);
        #1;
        i_s_axil_arvalid = 1'b0;
        while (!o_s_axil_rvalid) @(negedge core_clk_ifc);
        check_value("o_s_axil_rresp", 32'(o_s_axil_rresp), 32'd0);
        check_value($sformatf("o_s_axil_rdata[0x%02h]", addr), o_s_axil_rdata, exp);
        @(posedge core_clk_ifc);
        #1;
    endtask

    //////////////////////////////////////////////////
    // Packet traffic and scoreboards

    // Byte HDR carries the ingress port so the egress side can pick a scoreboard
    task automatic send_packet(input int p, input mac_addr_t mac, input int egr,
                               input int len, input bit routed);
        byte_t pkt [$];
        for (int i = 0; i < len; i++) begin
            if (i < HDR) begin
                pkt.push_back(mac[8*(HDR-1-i) +: 8]);
            end else if (i == HDR) begin
                pkt.push_back(byte_t'(p));
            end else begin
                pkt.push_back(byte_t'($random(seed)));
            end
            if (routed) begin
                exp_q[egr*N + p].push_back({i == len - 1, pkt[i]});
            end
        end
        if (routed) begin
            sent_pkts++;
        end
        @(posedge core_clk_ifc);
        #1;
        for (int i = 0; i < len; i++) begin
            i_ing_tdata[p] = pkt[i];
            i_ing_tvalid[p] = 1'b1;
            i_ing_tlast[p] = (i == len - 1);
            do @(negedge core_clk_ifc); while (!o_ing_tready[p]);
            @(posedge core_clk_ifc);
            #1;
        end
        i_ing_tvalid[p] = 1'b0;
        i_ing_tlast[p] = 1'b0;
    endtask

    task automatic send_burst(input int p);
        int entry;
        for (int k = 0; k < 16; k++) begin
            // First packet of both ports aims at one egress together
            entry = (k == 0) ? 0 : (($random(seed) & 32'h7fff_ffff) % 3);
            send_packet(p, MACS[entry], entry % 2, random_len(), 1'b1);
        end
    endtask

    task automatic check_packet(input int e);
        int src;
        logic [8:0] exp;
        src = int'(got_buf[e][HDR][7:0]);
        if (got_buf[e].size() <= HDR || src >= N) begin
            $display("Egress port %0d sent a packet that no ingress port routed", e);
            stop_on_failure();
        end else begin
            while (got_buf[e].size() > 0) begin
                if (exp_q[e*N + src].size() == 0) begin
                    $display("Egress port %0d sent more bytes than ingress %0d routed", e, src);
                    stop_on_failure();
                end
                exp = exp_q[e*N + src].pop_front();
                check_value($sformatf("o_egr_tdata[%0d]", e), 32'(got_buf[e][0][7:0]),
                            32'(exp[7:0]));
                check_value($sformatf("o_egr_tlast[%0d]", e), 32'(got_buf[e][0][8]),
                            32'(exp[8]));
                void'(got_buf[e].pop_front());
            end
            got_pkts++;
        end
    endtask

    always @(posedge core_clk_ifc) begin : egress_backpressure
        #1;
        for (int e = 0; e < N; e++) begin
            i_egr_tready[e] = bp_en ? (($random(seed) & 3) != 0) : 1'b1;
        end
    end

    // A transfer seen here completes at the next rising edge
    always @(negedge core_clk_ifc) begin : egress_monitor
        for (int e = 0; e < N; e++) begin
            if (i_rst_n && o_egr_tvalid[e] && i_egr_tready[e]) begin
                got_buf[e].push_back({o_egr_tlast[e], o_egr_tdata[e]});
                if (o_egr_tlast[e]) begin
                    check_packet(e);
                end
            end
        end
    end

    a_ready_after_reset: assert property (@(posedge core_clk_ifc)
        $rose(i_rst_n) |-> (o_ing_tready == '0))
        else begin
            $display("Ingress ready was high in the first cycle after reset");
            stop_on_failure();
        end

    for (genvar g = 0; g < N; g++) begin : g_egr_hold
        a_egr_hold: assert property (@(posedge core_clk_ifc) disable iff (!i_rst_n)
            o_egr_tvalid[g] && !i_egr_tready[g] |=>
            o_egr_tvalid[g] && $stable(o_egr_tdata[g]) && $stable(o_egr_tlast[g]))
            else begin
                $display("Egress port %0d lost or changed its byte while stalled", g);
                stop_on_failure();
            end
    end

    //////////////////////////////////////////////////
    // Test sequence

    initial begin : main
        i_rst_n = 1'b0;
        for (int p = 0; p < N; p++) begin
            i_ing_tdata[p] = '0;
        end
        i_ing_tvalid = '0;
        i_ing_tlast = '0;
        i_s_axil_awaddr = '0;
        i_s_axil_awvalid = 1'b0;
        i_s_axil_wdata = '0;
        i_s_axil_wvalid = 1'b0;
        i_s_axil_bready = 1'b1;
        i_s_axil_araddr = '0;
        i_s_axil_arvalid = 1'b0;
        i_s_axil_rready = 1'b1;
        repeat (4) @(posedge core_clk_ifc);
        #1;
        i_rst_n = 1'b1;
        @(negedge core_clk_ifc);
        check_value("o_egr_tvalid", 32'(o_egr_tvalid), 32'd0);
        check_value("o_s_axil_bvalid", 32'(o_s_axil_bvalid), 32'd0);
        check_value("o_s_axil_rvalid", 32'(o_s_axil_rvalid), 32'd0);
        read_expect(axil_addr_t'(`ROUTER_REG_DROP_CNT), 32'd0);

        // Program the table with unused bits set, then read every word back
        for (int e = 0; e < `ROUTER_MAC_ENTRIES; e++) begin
            axil_write(axil_addr_t'(8 * e), MACS[e][31:0]);
            axil_write(axil_addr_t'(8 * e + 4), {1'b1, 14'h3fff, 1'(e % 2), MACS[e][47:32]});
        end
        for (int e = 0; e < `ROUTER_MAC_ENTRIES; e++) begin
            read_expect(axil_addr_t'(8 * e), MACS[e][31:0]);
            read_expect(axil_addr_t'(8 * e + 4), {1'b1, 14'd0, 1'(e % 2), MACS[e][47:32]});
        end

        // Each ingress to each egress, egress always ready
        for (int p = 0; p < N; p++) begin
            for (int e = 0; e < N; e++) begin
                send_packet(p, MACS[e], e, random_len(), 1'b1);
            end
        end
        while (pending_bytes() != 0) @(posedge core_clk_ifc);

        // Unknown MAC, runt, then an entry that was invalidated
        send_packet(0, UNKNOWN_MAC, 0, 20, 1'b0);
        send_packet(1, MACS[1], 1, 4, 1'b0);
        axil_write(axil_addr_t'(8 * 3 + 4), {1'b0, 14'd0, 1'b1, MACS[3][47:32]});
        send_packet(0, MACS[3], 1, 30, 1'b0);
        read_expect(axil_addr_t'(`ROUTER_REG_DROP_CNT), 32'd3);

        bp_en = 1'b1;
        fork
            send_burst(0);
            send_burst(1);
        join
        while (pending_bytes() != 0) @(posedge core_clk_ifc);

        if (got_pkts == sent_pkts) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("Egress delivered %0d of %0d routed packets", got_pkts, sent_pkts);
            stop_on_failure();
        end
    end

endmodule

//--- verilog.f
+incdir+src
src/eth_pkg.sv
src/ctrl_pkg.sv
src/pkt_stream_if.sv
src/axil_regs.sv
src/ingress_classifier.sv
src/egress_arbiter.sv
src/router_top.sv
tb/router_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --timing --assert --timescale 1ns/1ps
TOP      = router_tb
FILELIST = verilog.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
